/* cpuDatapath.f */
+incdir+logic
+incdir+tb
logic/datapathPkg.sv
logic/uopIf.sv
logic/registerFile.sv
logic/aluUnit.sv
logic/instrDecoder.sv
logic/uopQueue.sv
logic/executeSequencer.sv
logic/cpuDatapath.sv
tb/cpuDatapathTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Builds the cpuDatapath testbench with Verilator, runs it and checks the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
        --top-module cpuDatapathTb -f cpuDatapath.f -o cpuDatapathSim \
        || { echo "Verilator build failed"; exit 1; }

simOutput=$(./obj_dir/cpuDatapathSim)
echo "$simOutput"

echo "$simOutput" | grep -qx "Test OK" \
        && exit 0 \
        || { echo "Simulation did not pass"; exit 1; }

/* tb/refModel.svh */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// Register model and expected write-back stream, in command acceptance order
logic [`DATA_WIDTH-1:0]     modelRegs [`REG_COUNT];
logic [`REG_IDX_WIDTH-1:0]  expReg [$];
logic [`DATA_WIDTH-1:0]     expData [$];
string                      expName [$];

aluOpT legalOps [11] = '{opAdd, opSub, opAnd, opOr, opShr, opShra,
                         opShl, opRor, opRol, opNeg, opNot};

function automatic void clearModel();
        foreach (modelRegs[i])
                modelRegs[i] = '0;
endfunction

function automatic logic isLegalOpcode(input logic [4:0] opBits);
        logic found;
        found = 1'b0;
        foreach (legalOps[i]) begin
                if (legalOps[i] == opBits)
                        found = 1'b1;
        end
        return found;
endfunction

// Result of Y op C, shift and rotate amounts come from the low 5 bits of C
function automatic logic [`DATA_WIDTH-1:0] refAlu(input aluOpT op,
                                                  input logic [`DATA_WIDTH-1:0] y,
                                                  input logic [`DATA_WIDTH-1:0] c);
        logic [4:0]              amt;
        logic [`DATA_WIDTH-1:0]  signFill;
        amt = c[4:0];
        signFill = '0;
        if (y[`DATA_WIDTH-1])
                signFill = ~({`DATA_WIDTH{1'b1}} >> amt);
        case (op)
                opAdd:   return y + c;
                opSub:   return y - c;
                opAnd:   return y & c;
                opOr:    return y | c;
                opShr:   return y >> amt;
                opShra:  return (y >> amt) | signFill;
                opShl:   return y << amt;
                opRor:   return (y >> amt) | (y << (6'd32 - {1'b0, amt}));
                opRol:   return (y << amt) | (y >> (6'd32 - {1'b0, amt}));
                opNeg:   return ~c + 1'b1;
                opNot:   return ~c;
                default: return c;
        endcase
endfunction

function automatic logic [`DATA_WIDTH-1:0] buildInstr(input logic [4:0] opBits,
                                                      input logic [`REG_IDX_WIDTH-1:0] ra,
                                                      input logic [`REG_IDX_WIDTH-1:0] rb,
                                                      input logic [`REG_IDX_WIDTH-1:0] rc);
        logic [`DATA_WIDTH-1:0] word;
        word = '0;
        word[opcodeMsb:opcodeLsb] = opBits;
        word[raMsb:raLsb] = ra;
        word[rbMsb:rbLsb] = rb;
        word[rcMsb:rcLsb] = rc;
        return word;
endfunction

// Updates the model for one accepted command, returns 0 when no write-back follows
function automatic logic applyToModel(input logic isLoad,
                                      input logic [`REG_IDX_WIDTH-1:0] regIdx,
                                      input logic [`DATA_WIDTH-1:0] word,
                                      input string name);
        logic [4:0]                 opBits;
        logic [`REG_IDX_WIDTH-1:0]  ra;
        logic [`DATA_WIDTH-1:0]     result;
        opBits = word[opcodeMsb:opcodeLsb];
        ra = word[raMsb:raLsb];
        if (isLoad) begin
                ra = regIdx;
                result = word;
        end else if (isLegalOpcode(opBits)) begin
                result = refAlu(aluOpT'(opBits), modelRegs[word[rbMsb:rbLsb]],
                                modelRegs[word[rcMsb:rcLsb]]);
        end else begin
                return 1'b0;
        end
        modelRegs[ra] = result;
        expReg.push_back(ra);
        expData.push_back(result);
        expName.push_back(name);
        return 1'b1;
endfunction

`endif

/* tb/cpuDatapathTb.sv */
`timescale 1ns/1ps
`include "datapath_defs.svh"

module cpuDatapathTb;
        import datapathPkg::*;

        localparam int cmdTimeout   = 200;
        localparam int drainTimeout = 600;

        logic                       Clock;
        logic                       rstN;
        logic                       cmdValid;
        logic                       cmdReady;
        logic                       cmdIsLoad;
        logic [`REG_IDX_WIDTH-1:0]  cmdReg;
        logic [`DATA_WIDTH-1:0]     cmdWord;
        logic                       wbValid;
        logic [`REG_IDX_WIDTH-1:0]  wbReg;
        logic [`DATA_WIDTH-1:0]     wbData;
        logic                       illegalOp;

        int     errorCount;
        int     wbCount;
        int     illegalCount;
        int     expectedIllegal;
        int     seed;
        logic   sawStall;
        string  testName;

        logic [`REG_IDX_WIDTH-1:0]  lastWbReg;
        logic [`DATA_WIDTH-1:0]     lastWbData;

        `include "refModel.svh"

        cpuDatapath i_dut (
                .Clock     (Clock),
                .rstN      (rstN),
                .cmdValid  (cmdValid),
                .cmdReady  (cmdReady),
                .cmdIsLoad (cmdIsLoad),
                .cmdReg    (cmdReg),
                .cmdWord   (cmdWord),
                .wbValid   (wbValid),
                .wbReg     (wbReg),
                .wbData    (wbData),
                .illegalOp (illegalOp)
        );

        initial begin
                Clock = 1'b0;
                forever #2 Clock = ~Clock;
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Command driving and run control
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        task automatic endRun();
                $display("Run finished: %0d write-backs, %0d illegal pulses, %0d errors",
                         wbCount, illegalCount, errorCount);
                if (errorCount == 0)
                        $display("Test OK");
                else
                        $display("Test FAILED");
                $finish;
        endtask

        function automatic logic [`DATA_WIDTH-1:0] randomWord();
                return $random(seed);
        endfunction

        // The command transfers on the rising edge after cmdReady is seen high mid-cycle
        task automatic sendCommand(input logic isLoad, input logic [`REG_IDX_WIDTH-1:0] regIdx,
                                   input logic [`DATA_WIDTH-1:0] word);
                int   waited;
                logic wbExpected;
                waited = 0;
                @(negedge Clock);
                cmdValid  = 1'b1;
                cmdIsLoad = isLoad;
                cmdReg    = regIdx;
                cmdWord   = word;
                while (!cmdReady && waited < cmdTimeout) begin
                        sawStall = 1'b1;
                        @(negedge Clock);
                        waited++;
                end
                if (!cmdReady) begin
                        errorCount++;
                        $display("Timeout in %s: cmdReady stayed low for %0d cycles",
                                 testName, cmdTimeout);
                        endRun();
                end else begin
                        wbExpected = applyToModel(isLoad, regIdx, word, testName);
                        if (!wbExpected)
                                expectedIllegal++;
                end
        endtask

        task automatic sendLoad(input logic [`REG_IDX_WIDTH-1:0] regIdx,
                                input logic [`DATA_WIDTH-1:0] data);
                sendCommand(1'b1, regIdx, data);
        endtask

        task automatic sendInstr(input logic [4:0] opBits, input logic [`REG_IDX_WIDTH-1:0] ra,
                                 input logic [`REG_IDX_WIDTH-1:0] rb,
                                 input logic [`REG_IDX_WIDTH-1:0] rc);
                sendCommand(1'b0, '0, buildInstr(opBits, ra, rb, rc));
        endtask

        task automatic releaseCmd();
                @(negedge Clock);
                cmdValid = 1'b0;
        endtask

        task automatic waitDrain();
                int waited;
                waited = 0;
                while (expData.size() != 0 && waited < drainTimeout) begin
                        @(negedge Clock);
                        waited++;
                end
                if (expData.size() != 0) begin
                        errorCount++;
                        $display("Timeout in %s: %0d write-backs never arrived",
                                 testName, expData.size());
                        endRun();
                end
        endtask

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Write-back monitor sampled mid-cycle
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        always @(negedge Clock) begin : compareWriteBack
                logic [`REG_IDX_WIDTH-1:0]  expR;
                logic [`DATA_WIDTH-1:0]     expD;
                string                      name;
                if (rstN && illegalOp)
                        illegalCount++;
                if (rstN && wbValid) begin
                        lastWbReg  = wbReg;
                        lastWbData = wbData;
                        if (expData.size() == 0) begin
                                errorCount++;
                                $display("Unexpected write-back of %h to R%0d", wbData, wbReg);
                        end else begin
                                expR = expReg.pop_front();
                                expD = expData.pop_front();
                                name = expName.pop_front();
                                wbCount++;
                                if (wbReg !== expR) begin
                                        errorCount++;
                                        $display("Fail %s: register expected R%0d, actual R%0d",
                                                 name, expR, wbReg);
                                end
                                if (wbData !== expD) begin
                                        errorCount++;
                                        $display("Fail %s: data expected %h, actual %h",
                                                 name, expD, wbData);
                                end
                        end
                end
        end

        initial begin
                logic [`DATA_WIDTH-1:0]     word;
                logic [`REG_IDX_WIDTH-1:0]  prevReg;
                errorCount      = 0;
                wbCount         = 0;
                illegalCount    = 0;
                expectedIllegal = 0;
                seed            = 22;
                sawStall        = 1'b0;
                testName        = "reset";
                lastWbReg       = '0;
                lastWbData      = '0;
                rstN      = 1'b0;
                cmdValid  = 1'b0;
                cmdIsLoad = 1'b0;
                cmdReg    = '0;
                cmdWord   = '0;
                clearModel();
                repeat (10) @(negedge Clock);
                rstN = 1'b1;
                @(negedge Clock);
                if (wbValid !== 1'b0 || illegalOp !== 1'b0) begin
                        errorCount++;
                        $display("wbValid or illegalOp was not low right after reset");
                end

                // Registers never loaded must read as zero
                testName = "resetZero";
                sendInstr(opNot, 4'd1, 4'd5, 4'd6);
                sendInstr(opAdd, 4'd2, 4'd8, 4'd9);
                releaseCmd();
                waitDrain();

                testName = "reference";
                sendLoad(4'd4, 32'h12);
                sendLoad(4'd3, 32'h7F);
                sendLoad(4'd7, 32'h02);
                sendCommand(1'b0, 4'd0, 32'h521B8000);
                releaseCmd();
                waitDrain();
                if (buildInstr(opShra, 4'd4, 4'd3, 4'd7) !== 32'h521B8000) begin
                        errorCount++;
                        $display("Fail %s: encoding expected 521b8000, actual %h", testName,
                                 buildInstr(opShra, 4'd4, 4'd3, 4'd7));
                end
                if (lastWbReg !== 4'd4 || lastWbData !== 32'h1F) begin
                        errorCount++;
                        $display("Fail %s: shra expected R4 = 0000001f, actual R%0d = %h",
                                 testName, lastWbReg, lastWbData);
                end

                testName = "allOpcodes";
                for (int r = 0; r < `REG_COUNT; r++)
                        sendLoad(r[3:0], randomWord());
                for (int pass = 0; pass < 3; pass++) begin
                        for (int k = 0; k < 11; k++) begin
                                word = randomWord();
                                sendLoad(word[15:12], randomWord());
                                sendInstr(legalOps[k], word[3:0], word[7:4], word[11:8]);
                        end
                end
                releaseCmd();
                waitDrain();

                // Each instruction reads the register written just before it
                testName = "dependency";
                prevReg = 4'd0;
                for (int k = 0; k < 14; k++) begin
                        word = randomWord();
                        sendInstr(legalOps[k % 11], word[3:0], prevReg,
                                  k[0] ? prevReg : word[7:4]);
                        prevReg = word[3:0];
                end
                releaseCmd();
                waitDrain();

                testName = "backPressure";
                sawStall = 1'b0;
                for (int k = 0; k < `UOP_QUEUE_DEPTH + 8; k++) begin
                        word = randomWord();
                        sendInstr(legalOps[k % 11], word[3:0], word[7:4], word[11:8]);
                end
                releaseCmd();
                if (!sawStall) begin
                        errorCount++;
                        $display("cmdReady never dropped during the %s burst", testName);
                end
                waitDrain();

                testName = "illegal";
                sendLoad(4'd10, 32'hA5A5_0F0F);
                sendLoad(4'd11, 32'h0000_0003);
                sendInstr(5'b00000, 4'd10, 4'd11, 4'd11);
                sendInstr(5'b01100, 4'd10, 4'd11, 4'd11);
                sendInstr(5'b10100, 4'd10, 4'd11, 4'd11);
                sendInstr(5'b11111, 4'd10, 4'd11, 4'd11);
                sendInstr(opAdd, 4'd12, 4'd10, 4'd11);
                releaseCmd();
                waitDrain();
                if (illegalCount != expectedIllegal) begin
                        errorCount++;
                        $display("Fail %s: illegalOp pulses expected %0d, actual %0d",
                                 testName, expectedIllegal, illegalCount);
                end

                // Quiet period so a stray write-back still reaches the monitor
                repeat (8) @(negedge Clock);
                endRun();
        end

endmodule

/* logic/cpuDatapath.sv */
`timescale 1ns/1ps
`include "datapath_defs.svh"

module cpuDatapath (
        input  logic                       Clock,
        input  logic                       rstN,
        input  logic                       cmdValid,
        output logic                       cmdReady,
        input  logic                       cmdIsLoad,
        input  logic [`REG_IDX_WIDTH-1:0]  cmdReg,
        input  logic [`DATA_WIDTH-1:0]     cmdWord,
        output logic                       wbValid,
        output logic [`REG_IDX_WIDTH-1:0]  wbReg,
        output logic [`DATA_WIDTH-1:0]     wbData,
        output logic                       illegalOp
);

        // Decoder to queue, then queue to sequencer
        uopIf decodedUop ();
        uopIf queuedUop ();

        instrDecoder decoder (
                .Clock     (Clock),
                .rstN      (rstN),
                .cmdValid  (cmdValid),
                .cmdReady  (cmdReady),
                .cmdIsLoad (cmdIsLoad),
                .cmdReg    (cmdReg),
                .cmdWord   (cmdWord),
                .illegalOp (illegalOp),
                .uopOut    (decodedUop.producer)
        );

        uopQueue queue (
                .Clock  (Clock),
                .rstN   (rstN),
                .uopIn  (decodedUop.consumer),
                .uopOut (queuedUop.producer)
        );

        executeSequencer sequencer (
                .Clock   (Clock),
                .rstN    (rstN),
                .uopIn   (queuedUop.consumer),
                .wbValid (wbValid),
                .wbReg   (wbReg),
                .wbData  (wbData)
        );

endmodule

/* logic/executeSequencer.sv */
`timescale 1ns/1ps
`include "datapath_defs.svh"

module executeSequencer (
        input  logic                       Clock,
        input  logic                       rstN,
        uopIf.consumer                     uopIn,
        output logic                       wbValid,
        output logic [`REG_IDX_WIDTH-1:0]  wbReg,
        output logic [`DATA_WIDTH-1:0]     wbData
);
        import datapathPkg::*;

        seqStateT                   state;
        logic                       accept;

        aluOpT                      curOp;
        logic [`REG_IDX_WIDTH-1:0]  curDest;
        logic [`REG_IDX_WIDTH-1:0]  curSrcB;
        logic [`REG_IDX_WIDTH-1:0]  curSrcC;

        logic [`DATA_WIDTH-1:0]     regY;
        logic [`DATA_WIDTH-1:0]     regZ;
        logic [`DATA_WIDTH-1:0]     readDataB;
        logic [`DATA_WIDTH-1:0]     readDataC;
        logic [`DATA_WIDTH-1:0]     aluResult;

        // One micro-operation at a time, new work only from Idle
        assign uopIn.ready = state == Idle;
        assign accept      = uopIn.valid && uopIn.ready;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Phase sequencing
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        always_ff @(posedge Clock) begin
                if (!rstN) begin
                        state <= Idle;
                end else begin
                        case (state)
                                Idle: begin
                                        if (accept)
                                                state <= (uopIn.op == opLoad) ? WriteBack
                                                                              : ReadOperand;
                                end
                                ReadOperand: state <= Execute;
                                Execute:     state <= WriteBack;
                                WriteBack:   state <= Idle;
                                default:     state <= Idle;
                        endcase
                end
        end

        always_ff @(posedge Clock) begin
                if (accept) begin
                        curOp   <= uopIn.op;
                        curDest <= uopIn.destReg;
                        curSrcB <= uopIn.srcRegB;
                        curSrcC <= uopIn.srcRegC;
                end
                if (state == ReadOperand)
                        regY <= readDataB;
                // A load parks its data in Z so write-back is the same for both paths
                if (accept && uopIn.op == opLoad)
                        regZ <= uopIn.data;
                else if (state == Execute)
                        regZ <= aluResult;
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Register file, ALU and write-back report
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        assign wbValid = state == WriteBack;
        assign wbReg   = curDest;
        assign wbData  = regZ;

        registerFile regFile (
                .Clock       (Clock),
                .rstN        (rstN),
                .readRegB    (curSrcB),
                .readDataB   (readDataB),
                .readRegC    (curSrcC),
                .readDataC   (readDataC),
                .writeEnable (wbValid),
                .writeReg    (curDest),
                .writeData   (regZ)
        );

        aluUnit alu (
                .op       (curOp),
                .operandY (regY),
                .operandC (readDataC),
                .result   (aluResult)
        );

endmodule

/* logic/uopQueue.sv */
`timescale 1ns/1ps
`include "datapath_defs.svh"

module uopQueue (
        input  logic     Clock,
        input  logic     rstN,
        uopIf.consumer   uopIn,
        uopIf.producer   uopOut
);
        import datapathPkg::*;

        localparam int depth    = `UOP_QUEUE_DEPTH;
        localparam int ptrWidth = $clog2(depth);
        localparam int cntWidth = $clog2(depth) + 1;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Storage, one array per micro-operation field
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        aluOpT                      opMem    [depth];
        logic [`REG_IDX_WIDTH-1:0]  destMem  [depth];
        logic [`REG_IDX_WIDTH-1:0]  srcBMem  [depth];
        logic [`REG_IDX_WIDTH-1:0]  srcCMem  [depth];
        logic [`DATA_WIDTH-1:0]     dataMem  [depth];

        logic [ptrWidth-1:0]        wrPtr;
        logic [ptrWidth-1:0]        rdPtr;
        logic [cntWidth-1:0]        count;
        logic                       wrFire;
        logic                       rdFire;

        assign uopIn.ready  = count != cntWidth'(depth);
        assign uopOut.valid = count != '0;

        assign wrFire = uopIn.valid && uopIn.ready;
        assign rdFire = uopOut.valid && uopOut.ready;

        // The head entry stays put until it is taken, so the payload is stable
        assign uopOut.op      = opMem[rdPtr];
        assign uopOut.destReg = destMem[rdPtr];
        assign uopOut.srcRegB = srcBMem[rdPtr];
        assign uopOut.srcRegC = srcCMem[rdPtr];
        assign uopOut.data    = dataMem[rdPtr];

        always_ff @(posedge Clock) begin
                if (wrFire) begin
                        opMem[wrPtr]   <= uopIn.op;
                        destMem[wrPtr] <= uopIn.destReg;
                        srcBMem[wrPtr] <= uopIn.srcRegB;
                        srcCMem[wrPtr] <= uopIn.srcRegC;
                        dataMem[wrPtr] <= uopIn.data;
                end
        end

        always_ff @(posedge Clock) begin
                if (!rstN) begin
                        wrPtr <= '0;
                        rdPtr <= '0;
                        count <= '0;
                end else begin
                        if (wrFire)
                                wrPtr <= wrPtr + 1'b1;
                        if (rdFire)
                                rdPtr <= rdPtr + 1'b1;
                        case ({wrFire, rdFire})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

endmodule

/* logic/instrDecoder.sv */
`timescale 1ns/1ps
`include "datapath_defs.svh"

module instrDecoder (
        input  logic                       Clock,
        input  logic                       rstN,
        input  logic                       cmdValid,
        output logic                       cmdReady,
        input  logic                       cmdIsLoad,
        input  logic [`REG_IDX_WIDTH-1:0]  cmdReg,
        input  logic [`DATA_WIDTH-1:0]     cmdWord,
        output logic                       illegalOp,
        uopIf.producer                     uopOut
);
        import datapathPkg::*;

        logic                             running;
        logic                             cmdFire;
        logic                             opLegal;
        logic [opcodeMsb-opcodeLsb:0]     opField;

        assign opField = cmdWord[opcodeMsb:opcodeLsb];

        always_comb begin
                case (aluOpT'(opField))
                        opAdd, opSub, opAnd, opOr, opRor, opRol,
                        opShr, opShra, opShl, opNeg, opNot: opLegal = 1'b1;
                        default: opLegal = 1'b0;
                endcase
        end

        // The single output slot takes a new command when empty or being drained
        assign cmdReady = running && (!uopOut.valid || uopOut.ready);
        assign cmdFire  = cmdValid && cmdReady;

        always_ff @(posedge Clock) begin
                if (!rstN) begin
                        running      <= 1'b0;
                        uopOut.valid <= 1'b0;
                        illegalOp    <= 1'b0;
                end else begin
                        running   <= 1'b1;
                        illegalOp <= cmdFire && !cmdIsLoad && !opLegal;
                        if (cmdFire) begin
                                // Illegal words are consumed here and leave the slot empty
                                uopOut.valid <= cmdIsLoad || opLegal;
                        end else if (uopOut.ready) begin
                                uopOut.valid <= 1'b0;
                        end
                end
        end

        always_ff @(posedge Clock) begin
                if (cmdFire) begin
                        uopOut.op      <= cmdIsLoad ? opLoad : aluOpT'(opField);
                        uopOut.destReg <= cmdIsLoad ? cmdReg : cmdWord[raMsb:raLsb];
                        uopOut.srcRegB <= cmdWord[rbMsb:rbLsb];
                        uopOut.srcRegC <= cmdWord[rcMsb:rcLsb];
                        uopOut.data    <= cmdWord;
                end
        end

endmodule

/* logic/aluUnit.sv */
`timescale 1ns/1ps
`include "datapath_defs.svh"

module aluUnit (
        input  datapathPkg::aluOpT          op,
        input  logic [`DATA_WIDTH-1:0]      operandY,
        input  logic [`DATA_WIDTH-1:0]      operandC,
        output logic [`DATA_WIDTH-1:0]      result
);
        import datapathPkg::*;

        localparam int shiftBits = $clog2(`DATA_WIDTH);

        logic [shiftBits-1:0]          amount;
        logic [2*`DATA_WIDTH-1:0]      doubled;
        logic [2*`DATA_WIDTH-1:0]      rotRight;
        logic [2*`DATA_WIDTH-1:0]      rotLeft;

        assign amount = operandC[shiftBits-1:0];

        // Rotates shift a doubled copy of Y and keep the half that wrapped around
        assign doubled  = {operandY, operandY};
        assign rotRight = doubled >> amount;
        assign rotLeft  = doubled << amount;

        always_comb begin
                case (op)
                        opAdd:   result = operandY + operandC;
                        opSub:   result = operandY - operandC;
                        opAnd:   result = operandY & operandC;
                        opOr:    result = operandY | operandC;
                        opShr:   result = operandY >> amount;
                        opShra:  result = $unsigned($signed(operandY) >>> amount);
                        opShl:   result = operandY << amount;
                        opRor:   result = rotRight[`DATA_WIDTH-1:0];
                        opRol:   result = rotLeft[2*`DATA_WIDTH-1:`DATA_WIDTH];
                        opNeg:   result = '0 - operandC;
                        opNot:   result = ~operandC;
                        // Loads bypass the ALU
                        default: result = operandC;
                endcase
        end

endmodule

/* logic/registerFile.sv */
`timescale 1ns/1ps
`include "datapath_defs.svh"

module registerFile (
        input  logic                       Clock,
        input  logic                       rstN,
        input  logic [`REG_IDX_WIDTH-1:0]  readRegB,
        output logic [`DATA_WIDTH-1:0]     readDataB,
        input  logic [`REG_IDX_WIDTH-1:0]  readRegC,
        output logic [`DATA_WIDTH-1:0]     readDataC,
        input  logic                       writeEnable,
        input  logic [`REG_IDX_WIDTH-1:0]  writeReg,
        input  logic [`DATA_WIDTH-1:0]     writeData
);

        logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

        // Both read ports see a write only after the edge that performs it
        assign readDataB = regs[readRegB];
        assign readDataC = regs[readRegC];

        always_ff @(posedge Clock) begin
                if (!rstN) begin
                        for (int i = 0; i < `REG_COUNT; i++) begin
                                regs[i] <= '0;
                        end
                end else if (writeEnable) begin
                        regs[writeReg] <= writeData;
                end
        end

endmodule

/* logic/uopIf.sv */
`timescale 1ns/1ps
`include "datapath_defs.svh"

interface uopIf;
        import datapathPkg::*;

        logic                       valid;
        logic                       ready;
        aluOpT                      op;
        logic [`REG_IDX_WIDTH-1:0]  destReg;
        logic [`REG_IDX_WIDTH-1:0]  srcRegB;
        logic [`REG_IDX_WIDTH-1:0]  srcRegC;
        // Only meaningful for opLoad
        logic [`DATA_WIDTH-1:0]     data;

        modport producer (
                output valid, op, destReg, srcRegB, srcRegC, data,
                input  ready
        );

        modport consumer (
                input  valid, op, destReg, srcRegB, srcRegC, data,
                output ready
        );

endinterface

/* logic/datapathPkg.sv */
package datapathPkg;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // ALU opcodes as carried in bits 31..27 of an instruction word
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        typedef enum logic [4:0] {
                opAdd  = 5'b00011,
                opSub  = 5'b00100,
                opAnd  = 5'b00101,
                opOr   = 5'b00110,
                opRor  = 5'b00111,
                opRol  = 5'b01000,
                opShr  = 5'b01001,
                opShra = 5'b01010,
                opShl  = 5'b01011,
                opNeg  = 5'b10001,
                opNot  = 5'b10010,
                // Internal code for register preloads, never legal in an instruction word
                opLoad = 5'b11111
        } aluOpT;

        // Sequencer phases, ReadOperand is T3, Execute is T4, WriteBack is T5
        typedef enum logic [1:0] {
                Idle        = 2'd0,
                ReadOperand = 2'd1,
                Execute     = 2'd2,
                WriteBack   = 2'd3
        } seqStateT;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Instruction word field positions
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        localparam int opcodeMsb = 31;
        localparam int opcodeLsb = 27;
        localparam int raMsb     = 26;
        localparam int raLsb     = 23;
        localparam int rbMsb     = 22;
        localparam int rbLsb     = 19;
        localparam int rcMsb     = 18;
        localparam int rcLsb     = 15;

endpackage

/* logic/datapath_defs.svh */
`ifndef DATAPATH_DEFS_SVH
`define DATAPATH_DEFS_SVH

// Width of every register, command word and ALU operand
`define DATA_WIDTH 32

// Register file size and index width
`define REG_COUNT 16
`define REG_IDX_WIDTH 4

// Micro-operation queue depth, a power of two from 2 upward
`define UOP_QUEUE_DEPTH 4

`endif
